// File: decode_stage.f
verilog/rv_decode_pkg.sv
verilog/reg_file.sv
verilog/inst_hold.sv
verilog/inst_decoder.sv
verilog/hazard_detect.sv
verilog/id_ex_reg.sv
verilog/decode_stage.sv
sim/tb_decode_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_decode_stage -f decode_stage.f -o tb_decode_stage &&
./obj_dir/tb_decode_stage | tee /dev/stderr | grep -qF "Done: no errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: sim/tb_decode_stage.sv
// directed tests only; register file is filled with random data first, writes stay off outside the hazard test
module tb_decode_stage import rv_decode_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_CYCLES = 2000;

    logic            clk;
    logic            reset;
    logic [31:0]     inst;
    logic [31:0]     pc;
    logic            mem_stall;
    logic            branch_flush;
    stage_write_t    exe_write;
    stage_write_t    mem_write;
    stage_write_t    wb_write;
    rf_write_t       rf_write;
    logic            hazard_stall;
    id_ex_t          id_ex;

    logic [31:0]     rf_model [32];
    logic [31:0]     pc_cnt;
    int              errors;
    int              checks;
    int              cycles;

    decode_stage u_decode_stage (
        .clk          (clk),
        .reset        (reset),
        .inst         (inst),
        .pc           (pc),
        .mem_stall    (mem_stall),
        .branch_flush (branch_flush),
        .exe_write    (exe_write),
        .mem_write    (mem_write),
        .wb_write     (wb_write),
        .rf_write     (rf_write),
        .hazard_stall (hazard_stall),
        .id_ex        (id_ex)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    // instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] rf_read(input logic [4:0] addr);
        return (addr == 5'd0) ? 32'd0 : rf_model[addr];
    endfunction

    function automatic logic is_base_opcode(input logic [6:0] op);
        return op inside {7'h03, 7'h23, 7'h33, 7'h13, 7'h63, 7'h6f, 7'h67, 7'h37, 7'h17};
    endfunction

    function automatic id_ex_t bubble_id_ex();
        id_ex_t e;
        e          = '0;
        e.exe_fun  = ALU_ADD;
        e.mem_op   = MEM_X;
        e.wb_sel   = WB_X;
        return e;
    endfunction

    // expected id_ex from the RV32I encoding rules
    function automatic id_ex_t model_decode(input logic [31:0] i, input logic [31:0] p);
        id_ex_t      e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_j;
        logic [31:0] imm_u;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        known;
        alu_fun_e    f3_fun [8];
        alu_fun_e    br_fun [8];
        mem_op_e     ld_mem [8];
        wb_sel_e     ld_wb  [8];
        mem_op_e     st_mem [8];
        f3_fun = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
        br_fun = '{BR_BEQ, BR_BNE, ALU_ADD, ALU_ADD, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
        ld_mem = '{MEM_LB, MEM_LH, MEM_LW, MEM_X, MEM_LBU, MEM_LHU, MEM_X, MEM_X};
        ld_wb  = '{WB_MEMB, WB_MEMH, WB_MEMW, WB_X, WB_MEMBU, WB_MEMHU, WB_X, WB_X};
        st_mem = '{MEM_SB, MEM_SH, MEM_SW, MEM_X, MEM_X, MEM_X, MEM_X, MEM_X};
        a      = rf_read(i[19:15]);
        b      = rf_read(i[24:20]);
        f3     = i[14:12];
        f7     = i[31:25];
        imm_i  = 32'($signed(i) >>> 20);
        imm_s  = (imm_i & 32'hffff_ffe0) | {27'd0, i[11:7]};
        imm_j  = 32'($signed({i[31], i[19:12], i[20], i[30:21], 1'b0}));
        imm_u  = i & 32'hffff_f000;
        known  = 1'b1;
        e      = bubble_id_ex();
        e.wb_addr = i[11:7];
        case (i[6:0])
            7'h03: begin
                e.op1_data = a;
                e.op2_data = imm_i;
                e.rf_wen   = 1'b1;
                e.mem_op   = ld_mem[f3];
                e.wb_sel   = ld_wb[f3];
                known      = (ld_mem[f3] != MEM_X);
            end
            7'h23: begin
                e.op1_data = a;
                e.op2_data = imm_s;
                e.mem_op   = st_mem[f3];
                known      = (st_mem[f3] != MEM_X);
            end
            7'h33, 7'h13: begin
                e.op1_data = a;
                e.op2_data = (i[6:0] == 7'h33) ? b : imm_i;
                e.rf_wen   = 1'b1;
                e.wb_sel   = WB_ALU;
                e.exe_fun  = f3_fun[f3];
                if (f7 == 7'h20 && f3 == 3'd5) begin
                    e.exe_fun = ALU_SRA;
                end else if (f7 == 7'h20 && f3 == 3'd0 && i[6:0] == 7'h33) begin
                    e.exe_fun = ALU_SUB;
                end
                if (i[6:0] == 7'h33) begin
                    known = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                end else if (f3 == 3'd1 || f3 == 3'd5) begin
                    known = (f7 == 7'h00) || (f7 == 7'h20 && f3 == 3'd5);  // shift forms
                end
            end
            7'h63: begin
                e.op1_data = a;
                e.op2_data = b;
                e.exe_fun  = br_fun[f3];
                known      = (f3 != 3'd2 && f3 != 3'd3);
            end
            7'h6f, 7'h67: begin
                e.op1_data = (i[6:0] == 7'h6f) ? p : a;
                e.op2_data = (i[6:0] == 7'h6f) ? imm_j : imm_i;
                e.exe_fun  = (i[6:0] == 7'h6f) ? ALU_ADD : ALU_JALR;
                e.rf_wen   = 1'b1;
                e.wb_sel   = WB_PC;
                e.jmp_flg  = 1'b1;
                known      = (i[6:0] == 7'h6f) || (f3 == 3'd0);
            end
            7'h37, 7'h17: begin
                e.op1_data = (i[6:0] == 7'h17) ? p : 32'd0;
                e.op2_data = imm_u;
                e.rf_wen   = 1'b1;
                e.wb_sel   = WB_ALU;
            end
            default: known = 1'b0;
        endcase
        if (!known) begin
            e = bubble_id_ex();
        end
        // registered whatever the decode
        e.pc       = p;
        e.rs2_data = b;
        e.imm_b    = 32'($signed({i[31], i[7], i[30:25], i[11:8], 1'b0}));
        return e;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_id_ex(input id_ex_t exp);
        check_val("id_ex.pc", id_ex.pc, exp.pc);
        check_val("id_ex.op1_data", id_ex.op1_data, exp.op1_data);
        check_val("id_ex.op2_data", id_ex.op2_data, exp.op2_data);
        check_val("id_ex.rs2_data", id_ex.rs2_data, exp.rs2_data);
        check_val("id_ex.imm_b", id_ex.imm_b, exp.imm_b);
        check_val("id_ex.exe_fun", 32'(id_ex.exe_fun), 32'(exp.exe_fun));
        check_val("id_ex.mem_op", 32'(id_ex.mem_op), 32'(exp.mem_op));
        check_val("id_ex.rf_wen", 32'(id_ex.rf_wen), 32'(exp.rf_wen));
        check_val("id_ex.wb_sel", 32'(id_ex.wb_sel), 32'(exp.wb_sel));
        check_val("id_ex.wb_addr", 32'(id_ex.wb_addr), 32'(exp.wb_addr));
        check_val("id_ex.jmp_flg", 32'(id_ex.jmp_flg), 32'(exp.jmp_flg));
    endtask

    // one instruction in, its decode checked a cycle later
    task automatic run_one(input logic [31:0] i);
        id_ex_t      exp;
        logic [31:0] p;
        p      = pc_cnt;
        pc_cnt = pc_cnt + 32'd4;
        exp    = model_decode(i, p);
        @(posedge clk);
        inst <= i;
        pc   <= p;
        @(negedge clk);
        check_val("hazard_stall", 32'(hazard_stall), 32'd0);
        @(posedge clk);
        @(negedge clk);
        check_id_ex(exp);
    endtask

    task automatic load_registers();
        logic [31:0] d;
        for (int a = 1; a < 32; a++) begin
            d = $urandom;
            @(posedge clk);
            rf_write <= '{en: 1'b1, addr: 5'(a), data: d};
            rf_model[a] = d;
        end
        @(posedge clk);
        rf_write <= '0;
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_val("hazard_stall", 32'(hazard_stall), 32'd0);
        check_id_ex(bubble_id_ex());
    endtask

    task automatic test_alu();
        load_registers();
        run_one(enc_r(7'h00, 5'd7, 5'd6, 3'd0, 5'd9));     // add
        run_one(enc_r(7'h20, 5'd12, 5'd11, 3'd0, 5'd10));  // sub
        run_one(enc_r(7'h00, 5'd15, 5'd14, 3'd1, 5'd13));  // sll
        run_one(enc_r(7'h00, 5'd18, 5'd17, 3'd2, 5'd16));  // slt
        run_one(enc_i(12'hffb, 5'd20, 3'd7, 5'd19, 7'h13)); // andi -5
        run_one(enc_i(12'h7ff, 5'd22, 3'd4, 5'd21, 7'h13));
        run_one(enc_i({7'h20, 5'd13}, 5'd24, 3'd5, 5'd23, 7'h13)); // srai 13
        run_one(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd5));     // x0 sources
        run_one(enc_r(7'h20, 5'd3, 5'd0, 3'd0, 5'd4));
        run_one(enc_i(12'h123, 5'd0, 3'd7, 5'd5, 7'h13));
    endtask

    task automatic test_mem_branch_jump();
        for (int f = 0; f < 6; f++) begin
            run_one(enc_i(12'hffc, 5'd2, 3'(f), 5'd1, 7'h03));  // includes f3=3, undefined
        end
        run_one(enc_s(12'h008, 5'd3, 5'd4, 3'd0));
        run_one(enc_s(12'h801, 5'd5, 5'd6, 3'd1));
        run_one(enc_s(12'hfe0, 5'd7, 5'd8, 3'd2));
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                run_one(enc_b(13'h1ff4 - 13'(f * 8), 5'd9, 5'd10, 3'(f)));
            end
        end
        run_one(enc_j(21'h1ff800, 5'd1));   // jal -2048
        run_one(enc_j(21'h000ffe, 5'd0));
        run_one(enc_i(12'h00c, 5'd5, 3'd0, 5'd1, 7'h67));
        run_one(enc_u(20'habcde, 5'd7, 7'h37));
        run_one(enc_u(20'h80000, 5'd8, 7'h17));
    endtask

    task automatic hazard_case(input logic [31:0] i, input int stage, input logic wen,
                               input logic [4:0] addr, input logic exp_stall);
        id_ex_t       exp;
        stage_write_t w;
        w   = '{rf_wen: wen, wb_addr: addr};
        exp = exp_stall ? bubble_id_ex() : model_decode(i, pc_cnt);
        @(posedge clk);
        inst <= i;
        pc   <= pc_cnt;
        case (stage)
            0:       exe_write <= w;
            1:       mem_write <= w;
            default: wb_write  <= w;
        endcase
        @(negedge clk);
        check_val("hazard_stall", 32'(hazard_stall), 32'(exp_stall));
        @(posedge clk);
        exe_write <= '0;
        mem_write <= '0;
        wb_write  <= '0;
        @(negedge clk);
        check_id_ex(exp);
    endtask

    task automatic test_hazard();
        logic [31:0] i;
        i = enc_r(7'h00, 5'd7, 5'd6, 3'd0, 5'd9);
        hazard_case(i, 0, 1'b1, 5'd6, 1'b1);
        hazard_case(i, 1, 1'b1, 5'd7, 1'b1);
        hazard_case(i, 2, 1'b1, 5'd6, 1'b1);
        hazard_case(i, 2, 1'b1, 5'd7, 1'b1);
        hazard_case(i, 0, 1'b0, 5'd6, 1'b0);  // write disabled
        hazard_case(i, 1, 1'b1, 5'd9, 1'b0);
        run_one(i);                           // upstream repeats it
        i = enc_r(7'h00, 5'd7, 5'd0, 3'd0, 5'd9);
        hazard_case(i, 0, 1'b1, 5'd0, 1'b0);  // x0 target never stalls
        hazard_case(i, 1, 1'b1, 5'd0, 1'b0);
    endtask

    task automatic test_flush_stall();
        logic [31:0] a;
        logic [31:0] b;
        id_ex_t      exp;
        a = enc_r(7'h00, 5'd7, 5'd6, 3'd0, 5'd9);
        b = enc_i(12'h055, 5'd12, 3'd6, 5'd11, 7'h13);
        @(posedge clk);
        inst         <= a;
        pc           <= pc_cnt;
        branch_flush <= 1'b1;
        exe_write    <= '{rf_wen: 1'b1, wb_addr: 5'd6};
        @(negedge clk);
        check_val("hazard_stall", 32'(hazard_stall), 32'd0);
        @(posedge clk);
        branch_flush <= 1'b0;
        exe_write    <= '0;
        @(negedge clk);
        check_id_ex(model_decode(enc_i(12'h000, 5'd0, 3'd0, 5'd0, 7'h13), 32'd0));
        exp = model_decode(a, pc_cnt);
        run_one(a);
        @(posedge clk);
        inst      <= b;
        pc        <= pc_cnt;
        mem_stall <= 1'b1;
        @(posedge clk);
        mem_stall <= 1'b0;
        @(negedge clk);
        check_id_ex(exp);  // A decoded again
    endtask

    task automatic test_undefined();
        logic [31:0] i;
        for (int n = 0; n < 16; n++) begin
            i = $urandom;
            while (is_base_opcode(i[6:0])) begin
                i[6:0] = 7'($urandom);
            end
            run_one(i);
            check_val("id_ex.rf_wen", 32'(id_ex.rf_wen), 32'd0);
        end
        run_one(enc_r(7'h01, 5'd2, 5'd3, 3'd0, 5'd4));      // mul
        run_one(enc_s(12'h010, 5'd2, 5'd3, 3'd4));
        run_one(enc_b(13'h0010, 5'd2, 5'd3, 3'd2));
        run_one(enc_i(12'h000, 5'd3, 3'd1, 5'd4, 7'h67));
        run_one(enc_i({7'h20, 5'd3}, 5'd3, 3'd1, 5'd4, 7'h13));
    endtask

    initial begin
        void'($urandom(32'hf08aa99e));
        clk          = 1'b0;
        reset        = 1'b1;
        inst         = 32'h0000_0013;
        pc           = 32'd0;
        mem_stall    = 1'b0;
        branch_flush = 1'b0;
        exe_write    = '0;
        mem_write    = '0;
        wb_write     = '0;
        rf_write     = '0;
        pc_cnt       = 32'h0000_1000;
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        test_reset();
        test_alu();
        test_mem_branch_jump();
        test_hazard();
        test_flush_stall();
        test_undefined();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: verilog/decode_stage.sv
// one instruction per cycle, no valid strobe; upstream must repeat the instruction on hazard_stall
module decode_stage import rv_decode_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic [XLEN-1:0] inst,
    input  logic [XLEN-1:0] pc,
    input  logic            mem_stall,
    input  logic            branch_flush,
    input  stage_write_t    exe_write,
    input  stage_write_t    mem_write,
    input  stage_write_t    wb_write,
    input  rf_write_t       rf_write,
    output logic            hazard_stall,
    output id_ex_t          id_ex
);

    logic [XLEN-1:0] cur_inst;
    logic [XLEN-1:0] cur_pc;
    dec_ctrl_t       ctrl;
    imm_t            imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;

    inst_hold u_inst_hold (
        .clk          (clk),
        .reset        (reset),
        .inst         (inst),
        .pc           (pc),
        .mem_stall    (mem_stall),
        .branch_flush (branch_flush),
        .cur_inst     (cur_inst),
        .cur_pc       (cur_pc)
    );

    inst_decoder u_inst_decoder (
        .inst (cur_inst),
        .ctrl (ctrl),
        .imm  (imm)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rf_write (rf_write),
        .rs1_addr (ctrl.rs1_addr),
        .rs2_addr (ctrl.rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    hazard_detect u_hazard_detect (
        .rs1_addr     (ctrl.rs1_addr),
        .rs2_addr     (ctrl.rs2_addr),
        .exe_write    (exe_write),
        .mem_write    (mem_write),
        .wb_write     (wb_write),
        .branch_flush (branch_flush),
        .hazard_stall (hazard_stall)
    );

    id_ex_reg u_id_ex_reg (
        .clk          (clk),
        .reset        (reset),
        .cur_pc       (cur_pc),
        .ctrl         (ctrl),
        .imm          (imm),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .hazard_stall (hazard_stall),
        .id_ex        (id_ex)
    );

endmodule

// File: verilog/hazard_detect.sv
// conservative: stalls on any matching rs field, even one the instruction does not read
module hazard_detect import rv_decode_pkg::*; (
    input  logic [REG_ADDR_W-1:0] rs1_addr,
    input  logic [REG_ADDR_W-1:0] rs2_addr,
    input  stage_write_t          exe_write,
    input  stage_write_t          mem_write,
    input  stage_write_t          wb_write,
    input  logic                  branch_flush,
    output logic                  hazard_stall
);

    function automatic logic hit(input stage_write_t w, input logic [REG_ADDR_W-1:0] a);
        return w.rf_wen && w.wb_addr == a && a != '0;
    endfunction

    always_comb begin
        hazard_stall = !branch_flush && (
            hit(exe_write, rs1_addr) || hit(exe_write, rs2_addr) ||
            hit(mem_write, rs1_addr) || hit(mem_write, rs2_addr) ||
            hit(wb_write,  rs1_addr) || hit(wb_write,  rs2_addr));
    end

endmodule

// File: verilog/id_ex_reg.sv
// no back-pressure from execute; a stalled cycle always becomes a bubble
module id_ex_reg import rv_decode_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic [XLEN-1:0] cur_pc,
    input  dec_ctrl_t       ctrl,
    input  imm_t            imm,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic            hazard_stall,
    output id_ex_t          id_ex
);

    localparam id_ex_t ID_EX_BUBBLE = '{
        pc:       '0,
        op1_data: '0,
        op2_data: '0,
        rs2_data: '0,
        imm_b:    '0,
        exe_fun:  ALU_ADD,
        mem_op:   MEM_X,
        rf_wen:   1'b0,
        wb_sel:   WB_X,
        wb_addr:  '0,
        jmp_flg:  1'b0
    };

    id_ex_t nxt;

    always_comb begin
        nxt.pc = cur_pc;
        case (ctrl.op1_sel)
            OP1_RS1: nxt.op1_data = rs1_data;
            OP1_PC:  nxt.op1_data = cur_pc;
            default: nxt.op1_data = '0;
        endcase
        case (ctrl.op2_sel)
            OP2_RS2: nxt.op2_data = rs2_data;
            OP2_IMI: nxt.op2_data = imm.i;
            OP2_IMS: nxt.op2_data = imm.s;
            OP2_IMJ: nxt.op2_data = imm.j;
            OP2_IMU: nxt.op2_data = imm.u;
            default: nxt.op2_data = '0;
        endcase
        nxt.rs2_data = rs2_data;  // store data
        nxt.imm_b    = imm.b;     // branch target offset
        nxt.exe_fun  = ctrl.exe_fun;
        nxt.mem_op   = ctrl.mem_op;
        nxt.rf_wen   = ctrl.rf_wen;
        nxt.wb_sel   = ctrl.wb_sel;
        nxt.wb_addr  = ctrl.wb_addr;
        nxt.jmp_flg  = ctrl.jmp_flg;
    end

    always_ff @(posedge clk) begin
        if (reset || hazard_stall) begin
            id_ex <= ID_EX_BUBBLE;
        end else begin
            id_ex <= nxt;
        end
    end

    // a register write always carries a writeback source
    a_wen_has_wb: assert property (@(posedge clk) disable iff (reset)
        id_ex.rf_wen |-> id_ex.wb_sel != WB_X);

endmodule

// File: verilog/inst_decoder.sv
// RV32I only; any other encoding decodes to the bubble control, rs addresses still come from inst
module inst_decoder import rv_decode_pkg::*; (
    input  logic [XLEN-1:0] inst,
    output dec_ctrl_t       ctrl,
    output imm_t            imm
);

    localparam dec_ctrl_t DEC_BUBBLE = '{
        exe_fun:  ALU_ADD,
        op1_sel:  OP1_X,
        op2_sel:  OP2_X,
        mem_op:   MEM_X,
        rf_wen:   1'b0,
        wb_sel:   WB_X,
        wb_addr:  '0,
        rs1_addr: '0,
        rs2_addr: '0,
        jmp_flg:  1'b0
    };

    rv_opcode_e opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;

    assign opcode = rv_opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm.i = {{20{inst[31]}}, inst[31:20]};
    assign imm.s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm.b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm.j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm.u = {inst[31:12], 12'b0};

    // shared by reg and imm forms, alt picks sub/sra
    function automatic alu_fun_e base_alu(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctrl         = DEC_BUBBLE;
        legal        = 1'b1;
        ctrl.wb_addr = inst[11:7];
        case (opcode)
            OP_LOAD: begin
                ctrl.op1_sel = OP1_RS1;
                ctrl.op2_sel = OP2_IMI;
                ctrl.rf_wen  = 1'b1;
                case (funct3)
                    3'b000: begin
                        ctrl.mem_op = MEM_LB;
                        ctrl.wb_sel = WB_MEMB;
                    end
                    3'b001: begin
                        ctrl.mem_op = MEM_LH;
                        ctrl.wb_sel = WB_MEMH;
                    end
                    3'b010: begin
                        ctrl.mem_op = MEM_LW;
                        ctrl.wb_sel = WB_MEMW;
                    end
                    3'b100: begin
                        ctrl.mem_op = MEM_LBU;
                        ctrl.wb_sel = WB_MEMBU;
                    end
                    3'b101: begin
                        ctrl.mem_op = MEM_LHU;
                        ctrl.wb_sel = WB_MEMHU;
                    end
                    default: legal = 1'b0;
                endcase
            end
            OP_STORE: begin
                ctrl.op1_sel = OP1_RS1;
                ctrl.op2_sel = OP2_IMS;
                case (funct3)
                    3'b000:  ctrl.mem_op = MEM_SB;
                    3'b001:  ctrl.mem_op = MEM_SH;
                    3'b010:  ctrl.mem_op = MEM_SW;
                    default: legal = 1'b0;
                endcase
            end
            OP_REG: begin
                ctrl.op1_sel = OP1_RS1;
                ctrl.op2_sel = OP2_RS2;
                ctrl.rf_wen  = 1'b1;
                ctrl.wb_sel  = WB_ALU;
                ctrl.exe_fun = base_alu(funct3, funct7[5]);
                legal = (funct7 == 7'b0000000) ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OP_IMM: begin
                ctrl.op1_sel = OP1_RS1;
                ctrl.op2_sel = OP2_IMI;
                ctrl.rf_wen  = 1'b1;
                ctrl.wb_sel  = WB_ALU;
                ctrl.exe_fun = base_alu(funct3, funct3 == 3'b101 && funct7[5]);
                if (funct3 == 3'b001) begin
                    legal = (funct7 == 7'b0000000);  // slli
                end else if (funct3 == 3'b101) begin
                    legal = (funct7 == 7'b0000000 || funct7 == 7'b0100000);
                end
            end
            OP_BRANCH: begin
                ctrl.op1_sel = OP1_RS1;
                ctrl.op2_sel = OP2_RS2;
                case (funct3)
                    3'b000:  ctrl.exe_fun = BR_BEQ;
                    3'b001:  ctrl.exe_fun = BR_BNE;
                    3'b100:  ctrl.exe_fun = BR_BLT;
                    3'b101:  ctrl.exe_fun = BR_BGE;
                    3'b110:  ctrl.exe_fun = BR_BLTU;
                    3'b111:  ctrl.exe_fun = BR_BGEU;
                    default: legal = 1'b0;
                endcase
            end
            OP_JAL: begin
                ctrl.op1_sel = OP1_PC;
                ctrl.op2_sel = OP2_IMJ;
                ctrl.rf_wen  = 1'b1;
                ctrl.wb_sel  = WB_PC;
                ctrl.jmp_flg = 1'b1;
            end
            OP_JALR: begin
                ctrl.exe_fun = ALU_JALR;
                ctrl.op1_sel = OP1_RS1;
                ctrl.op2_sel = OP2_IMI;
                ctrl.rf_wen  = 1'b1;
                ctrl.wb_sel  = WB_PC;
                ctrl.jmp_flg = 1'b1;
                legal = (funct3 == 3'b000);
            end
            OP_LUI: begin
                ctrl.op2_sel = OP2_IMU;  // op1 reads as zero
                ctrl.rf_wen  = 1'b1;
                ctrl.wb_sel  = WB_ALU;
            end
            OP_AUIPC: begin
                ctrl.op1_sel = OP1_PC;
                ctrl.op2_sel = OP2_IMU;
                ctrl.rf_wen  = 1'b1;
                ctrl.wb_sel  = WB_ALU;
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            ctrl = DEC_BUBBLE;
        end
        ctrl.rs1_addr = inst[19:15];
        ctrl.rs2_addr = inst[24:20];
    end

endmodule

// File: verilog/inst_hold.sv
// flush beats mem_stall; the saved copy is only one instruction deep
module inst_hold import rv_decode_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic [XLEN-1:0] inst,
    input  logic [XLEN-1:0] pc,
    input  logic            mem_stall,
    input  logic            branch_flush,
    output logic [XLEN-1:0] cur_inst,
    output logic [XLEN-1:0] cur_pc
);

    logic [XLEN-1:0] save_inst;
    logic [XLEN-1:0] save_pc;

    always_comb begin
        if (branch_flush) begin
            cur_inst = INST_NOP;
            cur_pc   = PC_NOP;
        end else if (mem_stall) begin  // re-decode last cycle's instruction
            cur_inst = save_inst;
            cur_pc   = save_pc;
        end else begin
            cur_inst = inst;
            cur_pc   = pc;
        end
    end

    // cur_* is already the nop on a flush
    always_ff @(posedge clk) begin
        if (reset) begin
            save_inst <= INST_NOP;
            save_pc   <= PC_NOP;
        end else begin
            save_inst <= cur_inst;
            save_pc   <= cur_pc;
        end
    end

    // a flushed slot replayed by mem_stall stays the nop
    a_flush_saved_nop: assert property (@(posedge clk) disable iff (reset)
        branch_flush ##1 (mem_stall && !branch_flush)
            |-> (cur_inst == INST_NOP && cur_pc == PC_NOP));

endmodule

// File: verilog/reg_file.sv
// no reset, contents undefined until written; same-cycle write is not bypassed to the reads
module reg_file import rv_decode_pkg::*; (
    input  logic                  clk,
    input  rf_write_t             rf_write,
    input  logic [REG_ADDR_W-1:0] rs1_addr,
    input  logic [REG_ADDR_W-1:0] rs2_addr,
    output logic [XLEN-1:0]       rs1_data,
    output logic [XLEN-1:0]       rs2_data
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];  // entry 0 never written

    always_ff @(posedge clk) begin
        if (rf_write.en && rf_write.addr != '0) begin
            regs[rf_write.addr] <= rf_write.data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];  // x0 hardwired
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: verilog/rv_decode_pkg.sv
// RV32I base set only; no CSR, fence.i or M extension, all widths fixed by the ISA
package rv_decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] INST_NOP = 32'h0000_0013; // addi x0, x0, 0
    localparam logic [XLEN-1:0] PC_NOP   = '0;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111
    } rv_opcode_e;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_JALR,
        BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } alu_fun_e;

    typedef enum logic [1:0] {OP1_X, OP1_RS1, OP1_PC} op1_sel_e;

    typedef enum logic [2:0] {OP2_X, OP2_RS2, OP2_IMI, OP2_IMS, OP2_IMJ, OP2_IMU} op2_sel_e;

    typedef enum logic [3:0] {
        MEM_X, MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW, MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    typedef enum logic [2:0] {
        WB_X, WB_ALU, WB_MEMB, WB_MEMBU, WB_MEMH, WB_MEMHU, WB_MEMW, WB_PC
    } wb_sel_e;

    typedef struct packed {
        logic [XLEN-1:0] i;
        logic [XLEN-1:0] s;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] j;
        logic [XLEN-1:0] u;  // already shifted by 12
    } imm_t;

    typedef struct packed {
        alu_fun_e              exe_fun;
        op1_sel_e              op1_sel;
        op2_sel_e              op2_sel;
        mem_op_e               mem_op;
        logic                  rf_wen;
        wb_sel_e               wb_sel;
        logic [REG_ADDR_W-1:0] wb_addr;
        logic [REG_ADDR_W-1:0] rs1_addr;
        logic [REG_ADDR_W-1:0] rs2_addr;
        logic                  jmp_flg;
    } dec_ctrl_t;

    // pending write of one later stage
    typedef struct packed {
        logic                  rf_wen;
        logic [REG_ADDR_W-1:0] wb_addr;
    } stage_write_t;

    typedef struct packed {
        logic                  en;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } rf_write_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       op1_data;
        logic [XLEN-1:0]       op2_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm_b;
        alu_fun_e              exe_fun;
        mem_op_e               mem_op;
        logic                  rf_wen;
        wb_sel_e               wb_sel;
        logic [REG_ADDR_W-1:0] wb_addr;
        logic                  jmp_flg;
    } id_ex_t;

endpackage
